// File: Makefile
SRCS := $(shell grep -v '^+' project.f)

obj_dir/Vrhythm_tb: project.f $(SRCS)
	verilator --binary --timing --assert --top-module rhythm_tb -f project.f

.PHONY: run clean

run: obj_dir/Vrhythm_tb
	@out="$$(./obj_dir/Vrhythm_tb)"; echo "$$out"; \
		echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

// File: logic/i2s_player.sv
/*
 * I2S player
 * waits for the prefill count, prefetches one word ahead through the
 * arbiter and shifts words out as I2S slots, even words left, odd right.
 * a slot with no word ready goes out silent and sets a sticky underrun
 */
`default_nettype none

module i2s_player #(
	parameter int NUM_WORDS = 16,
	parameter int PREFILL   = 4,
	parameter int SCLK_HALF = 4
) (
	input  wire                  clk_i,
	input  wire                  arst_n_i,
	input  rhythm_pkg::addr_t    load_count_i,
	output logic                 mem_req_o,
	output rhythm_pkg::mem_req_t mem_cmd_o,
	input  wire                  mem_ack_i,
	input  rhythm_pkg::sample_t  mem_rdata_i,
	output logic                 i2s_sclk_o,
	output logic                 i2s_lrclk_o,
	output logic                 i2s_sd_o,
	output rhythm_pkg::addr_t    play_index_o,
	output logic                 play_done_o,
	output logic                 underrun_o
);

	localparam int DIV_W = $clog2(SCLK_HALF + 1);

	rhythm_pkg::play_state_e state_q;
	logic [DIV_W-1:0]        div_q;		// clocks within half a bit clock
	logic                    sclk_q;
	logic                    lrclk_q;
	logic [3:0]              bit_cnt_q;	// bit position inside the slot
	rhythm_pkg::sample_t     shift_q;
	rhythm_pkg::addr_t       play_idx_q;	// words fully played
	logic                    cur_word_q;	// current slot carries a real word
	logic                    underrun_q;
	// prefetch side
	rhythm_pkg::addr_t       fetch_idx_q;	// next word to read
	logic                    mem_req_q;
	logic                    pf_valid_q;
	rhythm_pkg::sample_t     pf_data_q;

	logic                    tick, fall, slot_end, last_done, take, fetch_ok;
	rhythm_pkg::addr_t       play_next;

	// ==================================================
	// timing strobes
	// ==================================================
	assign tick      = (div_q == DIV_W'(SCLK_HALF - 1));
	assign fall      = tick && sclk_q;	// sclk about to go low
	assign slot_end  = (state_q == rhythm_pkg::RUN) && fall && (bit_cnt_q == 4'd15);
	assign play_next = play_idx_q + rhythm_pkg::addr_t'(cur_word_q);
	assign last_done = (play_next == rhythm_pkg::addr_t'(NUM_WORDS));
	assign take      = slot_end && !last_done && pf_valid_q;	// prefetch into shifter

	// ==================================================
	// state, bit clock and shifter
	// ==================================================
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q    <= rhythm_pkg::IDLE;
			div_q      <= '0;
			sclk_q     <= 1'b0;
			lrclk_q    <= 1'b0;
			bit_cnt_q  <= '0;
			shift_q    <= '0;
			play_idx_q <= '0;
			cur_word_q <= 1'b0;
			underrun_q <= 1'b0;
		end else begin
			case (state_q)
				rhythm_pkg::IDLE: state_q <= rhythm_pkg::WAIT_PREFILL;
				rhythm_pkg::WAIT_PREFILL: begin
					if (load_count_i >= rhythm_pkg::addr_t'(PREFILL)) begin
						state_q <= rhythm_pkg::RUN;
						lrclk_q <= 1'b1;	// silent lead-in slot on the right
					end
				end
				rhythm_pkg::RUN: begin
					div_q <= tick ? '0 : div_q + 1'b1;
					if (tick) sclk_q <= ~sclk_q;
					if (fall) begin
						if (bit_cnt_q == 4'd15) begin	// slot boundary
							bit_cnt_q  <= '0;
							play_idx_q <= play_next;
							if (last_done) begin
								state_q <= rhythm_pkg::DONE;
								sclk_q  <= 1'b0;
								lrclk_q <= 1'b0;
								shift_q <= '0;
							end else if (pf_valid_q) begin
								shift_q    <= pf_data_q;
								cur_word_q <= 1'b1;
							end else begin
								shift_q    <= '0;	// word missing, send silence
								cur_word_q <= 1'b0;
								underrun_q <= 1'b1;
							end
						end else begin
							shift_q   <= {shift_q[14:0], 1'b0};
							bit_cnt_q <= bit_cnt_q + 1'b1;
							// lrclk leads the next MSB by one bit clock
							if (bit_cnt_q == 4'd14) lrclk_q <= ~lrclk_q;
						end
					end
				end
				default: ;	// DONE, lines stay low
			endcase
		end
	end

	// ==================================================
	// one-word prefetch over the client port
	// ==================================================
	assign fetch_ok = (state_q == rhythm_pkg::WAIT_PREFILL || state_q == rhythm_pkg::RUN) &&
		!pf_valid_q && !mem_ack_i && (fetch_idx_q < load_count_i);

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			mem_req_q   <= 1'b0;
			fetch_idx_q <= '0;
			pf_valid_q  <= 1'b0;
		end else begin
			if (mem_req_q) begin
				if (mem_ack_i) begin	// word arrived, drop req
					mem_req_q   <= 1'b0;
					pf_valid_q  <= 1'b1;
					fetch_idx_q <= fetch_idx_q + 1'b1;
				end
			end else if (fetch_ok) begin
				mem_req_q <= 1'b1;
			end
			if (take) pf_valid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk_i) begin
		if (mem_req_q && mem_ack_i) pf_data_q <= mem_rdata_i;
	end

	assign mem_req_o    = mem_req_q;
	assign mem_cmd_o    = '{addr: fetch_idx_q, wdata: '0, we: 1'b0};	// reads only
	assign i2s_sclk_o   = sclk_q;
	assign i2s_lrclk_o  = lrclk_q;
	assign i2s_sd_o     = shift_q[15];	// MSB first
	assign play_index_o = play_idx_q;
	assign play_done_o  = (state_q == rhythm_pkg::DONE);
	assign underrun_o   = underrun_q;

endmodule

`default_nettype wire

// File: logic/mem_arbiter.sv
/*
 * memory arbiter
 * shares the single-port sample memory between loader and player,
 * fixed priority to the loader, four-phase on both client ports
 */
`default_nettype none

module mem_arbiter (
	input  wire                  clk_i,
	input  wire                  arst_n_i,
	// loader client
	input  wire                  ld_req_i,
	input  rhythm_pkg::mem_req_t ld_cmd_i,
	output logic                 ld_ack_o,
	// player client
	input  wire                  pl_req_i,
	input  rhythm_pkg::mem_req_t pl_cmd_i,
	output logic                 pl_ack_o,
	output rhythm_pkg::sample_t  pl_rdata_o,
	// memory side
	output rhythm_pkg::mem_req_t ram_cmd_o,
	output logic                 ram_en_o,
	input  rhythm_pkg::sample_t  ram_rdata_i
);

	typedef enum logic [1:0] {AR_IDLE, AR_ISSUE, AR_LAT, AR_ACK} arb_state_e;

	arb_state_e          state_q;
	logic                gnt_ld_q;	// 1 loader owns the memory, 0 player
	logic                ack_q;
	rhythm_pkg::sample_t rdata_q;	// read word held for the ack phase
	logic                gnt_req;

	// req of whichever client holds the grant
	assign gnt_req = gnt_ld_q ? ld_req_i : pl_req_i;

	// ==================================================
	// grant and access sequencing
	// ==================================================
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q  <= AR_IDLE;
			gnt_ld_q <= 1'b0;
			ack_q    <= 1'b0;
		end else begin
			case (state_q)
				AR_IDLE: begin
					// both acks are low in here
					if (ld_req_i || pl_req_i) begin
						gnt_ld_q <= ld_req_i;	// loader wins a tie
						state_q  <= AR_ISSUE;
					end
				end
				AR_ISSUE: state_q <= AR_LAT;	// memory does the access this edge
				AR_LAT: begin
					ack_q   <= 1'b1;
					state_q <= AR_ACK;
				end
				default: begin
					if (!gnt_req) begin	// return to zero
						ack_q   <= 1'b0;
						state_q <= AR_IDLE;
					end
				end
			endcase
		end
	end

	// capture read data at the end of the latency cycle
	always_ff @(posedge clk_i) begin
		if (state_q == AR_LAT) rdata_q <= ram_rdata_i;
	end

	// ==================================================
	// outputs
	// ==================================================
	assign ram_en_o   = (state_q == AR_ISSUE);	// one access per grant
	assign ram_cmd_o  = gnt_ld_q ? ld_cmd_i : pl_cmd_i;
	assign ld_ack_o   = ack_q & gnt_ld_q;
	assign pl_ack_o   = ack_q & ~gnt_ld_q;
	assign pl_rdata_o = rdata_q;	// valid while pl ack is high

endmodule

`default_nettype wire

// File: logic/play_display.sv
/*
 * play index display
 * four active-low seven-segment digits, hex view of the play index
 */
`default_nettype none

module play_display (
	input  rhythm_pkg::addr_t play_index_i,
	output rhythm_pkg::seg_t  hex0_o,
	output rhythm_pkg::seg_t  hex1_o,
	output rhythm_pkg::seg_t  hex2_o,
	output rhythm_pkg::seg_t  hex3_o
);

	localparam int PAD = 16 - $bits(rhythm_pkg::addr_t);

	logic [15:0] idx_ext;

	// hex nibble to segments, low means lit
	function automatic rhythm_pkg::seg_t nib_to_seg(input logic [3:0] nib);
		case (nib)	//  gfedcba
			4'h0: return 7'b1000000;
			4'h1: return 7'b1111001;
			4'h2: return 7'b0100100;
			4'h3: return 7'b0110000;
			4'h4: return 7'b0011001;
			4'h5: return 7'b0010010;
			4'h6: return 7'b0000010;
			4'h7: return 7'b1111000;
			4'h8: return 7'b0000000;
			4'h9: return 7'b0010000;
			4'ha: return 7'b0001000;
			4'hb: return 7'b0000011;
			4'hc: return 7'b1000110;
			4'hd: return 7'b0100001;
			4'he: return 7'b0000110;
			default: return 7'b0001110;	// F
		endcase
	endfunction

	assign idx_ext = {{PAD{1'b0}}, play_index_i};	// top digits read zero

	assign hex0_o = nib_to_seg(idx_ext[3:0]);
	assign hex1_o = nib_to_seg(idx_ext[7:4]);
	assign hex2_o = nib_to_seg(idx_ext[11:8]);
	assign hex3_o = nib_to_seg(idx_ext[15:12]);

endmodule

`default_nettype wire

// File: logic/rhythm_audio_top.sv
/*
 * rhythm audio top
 * sample loader and I2S player sharing one sample memory through
 * the arbiter, plus the play index display
 */
`default_nettype none

module rhythm_audio_top #(
	parameter int NUM_WORDS = 16,
	parameter int PREFILL   = 4,
	parameter int SCLK_HALF = 4
) (
	input  wire                 MAX10_CLK2_50,
	input  wire                 arst_n_i,
	input  wire                 load_req_i,
	input  rhythm_pkg::sample_t load_data_i,
	output logic                load_ack_o,
	output logic                load_done_o,
	output logic                i2s_sclk_o,
	output logic                i2s_lrclk_o,
	output logic                i2s_sd_o,
	output logic                play_done_o,
	output logic                underrun_o,
	output rhythm_pkg::seg_t    hex0_o,
	output rhythm_pkg::seg_t    hex1_o,
	output rhythm_pkg::seg_t    hex2_o,
	output rhythm_pkg::seg_t    hex3_o
);

	// loader client port
	logic                 ld_req, ld_ack;
	rhythm_pkg::mem_req_t ld_cmd;
	// player client port
	logic                 pl_req, pl_ack;
	rhythm_pkg::mem_req_t pl_cmd;
	rhythm_pkg::sample_t  pl_rdata;
	// memory side
	logic                 ram_en;
	rhythm_pkg::mem_req_t ram_cmd;
	rhythm_pkg::sample_t  ram_rdata;
	rhythm_pkg::addr_t    load_count, play_index;

	sample_loader #(.NUM_WORDS(NUM_WORDS)) u_loader (
		.clk_i(MAX10_CLK2_50), .arst_n_i(arst_n_i),
		.load_req_i(load_req_i), .load_data_i(load_data_i), .load_ack_o(load_ack_o),
		.mem_req_o(ld_req), .mem_cmd_o(ld_cmd), .mem_ack_i(ld_ack),
		.load_count_o(load_count), .load_done_o(load_done_o)
	);

	mem_arbiter u_arbiter (
		.clk_i(MAX10_CLK2_50), .arst_n_i(arst_n_i),
		.ld_req_i(ld_req), .ld_cmd_i(ld_cmd), .ld_ack_o(ld_ack),
		.pl_req_i(pl_req), .pl_cmd_i(pl_cmd), .pl_ack_o(pl_ack), .pl_rdata_o(pl_rdata),
		.ram_cmd_o(ram_cmd), .ram_en_o(ram_en), .ram_rdata_i(ram_rdata)
	);

	sample_ram u_ram (
		.clk_i(MAX10_CLK2_50), .ram_en_i(ram_en),
		.ram_cmd_i(ram_cmd), .ram_rdata_o(ram_rdata)
	);

	i2s_player #(
		.NUM_WORDS(NUM_WORDS), .PREFILL(PREFILL), .SCLK_HALF(SCLK_HALF)
	) u_player (
		.clk_i(MAX10_CLK2_50), .arst_n_i(arst_n_i), .load_count_i(load_count),
		.mem_req_o(pl_req), .mem_cmd_o(pl_cmd), .mem_ack_i(pl_ack), .mem_rdata_i(pl_rdata),
		.i2s_sclk_o(i2s_sclk_o), .i2s_lrclk_o(i2s_lrclk_o), .i2s_sd_o(i2s_sd_o),
		.play_index_o(play_index), .play_done_o(play_done_o), .underrun_o(underrun_o)
	);

	play_display u_display (
		.play_index_i(play_index),
		.hex0_o(hex0_o), .hex1_o(hex1_o), .hex2_o(hex2_o), .hex3_o(hex3_o)
	);

endmodule

`default_nettype wire

// File: logic/rhythm_pkg.sv
/*
 * rhythm audio package
 * common types for the sample path of the rhythm game board,
 * used by the loader, the memory arbiter, the player and the display
 */
`default_nettype none

package rhythm_pkg;

	// ==================================================
	// basic widths
	// ==================================================
	typedef logic [15:0] sample_t;	// one audio word, signed by convention
	typedef logic [9:0]  addr_t;	// word address into sample memory
	typedef logic [6:0]  seg_t;	// active low, segment a in bit 0

	// ==================================================
	// memory client command
	// ==================================================
	// held by the client for as long as its req is high
	typedef struct packed {
		addr_t   addr;		// word address
		sample_t wdata;		// write data, ignored on reads
		logic    we;		// 1 write, 0 read
	} mem_req_t;

	// ==================================================
	// player FSM
	// ==================================================
	typedef enum logic [1:0] {
		IDLE         = 2'd0,	// just out of reset
		WAIT_PREFILL = 2'd1,	// waiting for enough stored words
		RUN          = 2'd2,	// frames going out
		DONE         = 2'd3	// all words played
	} play_state_e;

endpackage

`default_nettype wire

// File: logic/sample_loader.sv
/*
 * sample loader
 * accepts sample words over the external four-phase port and writes
 * them at consecutive addresses through the memory arbiter
 */
`default_nettype none

module sample_loader #(
	parameter int NUM_WORDS = 16
) (
	input  wire                  clk_i,
	input  wire                  arst_n_i,
	input  wire                  load_req_i,
	input  rhythm_pkg::sample_t  load_data_i,
	output logic                 load_ack_o,
	output logic                 mem_req_o,
	output rhythm_pkg::mem_req_t mem_cmd_o,
	input  wire                  mem_ack_i,
	output rhythm_pkg::addr_t    load_count_o,
	output logic                 load_done_o
);

	typedef enum logic [1:0] {LD_IDLE, LD_WRITE, LD_ACK, LD_DONE} ld_state_e;

	ld_state_e         state_q;
	rhythm_pkg::addr_t count_q;	// words stored so far, also next address
	logic              ack_q;

	// mem req goes up in the same cycle the source request is seen
	assign mem_req_o = (state_q == LD_WRITE) ||
		(state_q == LD_IDLE && load_req_i && !mem_ack_i);
	// source holds data while req is high, so it feeds the memory directly
	assign mem_cmd_o = '{addr: count_q, wdata: load_data_i, we: 1'b1};

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= LD_IDLE;
			count_q <= '0;
			ack_q   <= 1'b0;
		end else begin
			case (state_q)
				LD_IDLE: if (load_req_i && !mem_ack_i) state_q <= LD_WRITE;
				LD_WRITE: begin
					if (mem_ack_i) begin	// write landed
						count_q <= count_q + 1'b1;
						ack_q   <= 1'b1;
						state_q <= LD_ACK;
					end
				end
				LD_ACK: begin
					if (!load_req_i) begin	// source released, close the handshake
						ack_q   <= 1'b0;
						state_q <= (count_q == rhythm_pkg::addr_t'(NUM_WORDS)) ?
							LD_DONE : LD_IDLE;
					end
				end
				default: ;	// full, no more acks
			endcase
		end
	end

	assign load_ack_o   = ack_q;
	assign load_count_o = count_q;
	assign load_done_o  = (state_q == LD_DONE);

endmodule

`default_nettype wire

// File: logic/sample_ram.sv
/*
 * sample memory
 * single-port on-chip word store standing in for the SDRAM,
 * one access per enable, read data registered
 */
`default_nettype none

module sample_ram (
	input  wire                  clk_i,
	input  wire                  ram_en_i,
	input  rhythm_pkg::mem_req_t ram_cmd_i,
	output rhythm_pkg::sample_t  ram_rdata_o
);

	localparam int DEPTH = 2 ** $bits(rhythm_pkg::addr_t);	// 1024 words

	rhythm_pkg::sample_t mem_q [DEPTH];

	always_ff @(posedge clk_i) begin
		if (ram_en_i) begin
			if (ram_cmd_i.we) mem_q[ram_cmd_i.addr] <= ram_cmd_i.wdata;
			else ram_rdata_o <= mem_q[ram_cmd_i.addr];	// one cycle latency
		end
	end

endmodule

`default_nettype wire

// File: project.f
logic/rhythm_pkg.sv
logic/sample_loader.sv
logic/mem_arbiter.sv
logic/sample_ram.sv
logic/i2s_player.sv
logic/play_display.sv
logic/rhythm_audio_top.sv
verification/rhythm_assertions.sv
verification/rhythm_tb.sv

// File: verification/audio_patterns.txt
// lines 0..15: sample words in play order, none zero
// lines 16..19: expected hex0..hex3 segments at the end, active low, a in bit 0
1a2b
8001
7fff
c350
0001
fffe
3c3c
a5a5
5a5a
1234
edcb
0f0f
f0f0
4000
8000
2468
0040
0079
0040
0040

// File: verification/rhythm_assertions.sv
/*
 * arbiter checks
 * four-phase and grant rules on both client ports of the memory arbiter
 */
`default_nettype none

module rhythm_assertions (
	input wire                  clk_i,
	input wire                  arst_n_i,
	input wire                  ld_req_i,
	input rhythm_pkg::mem_req_t ld_cmd_i,
	input wire                  ld_ack_i,
	input wire                  pl_req_i,
	input rhythm_pkg::mem_req_t pl_cmd_i,
	input wire                  pl_ack_i
);

	timeunit 1ns;
	timeprecision 1ps;

	// one client served at a time
	acks_exclusive: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		!(ld_ack_i && pl_ack_i)) else $error("loader and player acks high together");

	ld_ack_needs_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		$rose(ld_ack_i) |-> ld_req_i) else $error("loader ack rose without its req");
	pl_ack_needs_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		$rose(pl_ack_i) |-> pl_req_i) else $error("player ack rose without its req");

	// command held through the handshake
	ld_cmd_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		ld_req_i && $past(ld_req_i) |-> $stable(ld_cmd_i)) else $error("loader cmd moved");
	pl_cmd_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		pl_req_i && $past(pl_req_i) |-> $stable(pl_cmd_i)) else $error("player cmd moved");

	// grant kept until the owner drops its req
	ld_ack_held: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		ld_ack_i && ld_req_i |=> ld_ack_i) else $error("loader ack fell before its req");
	pl_ack_held: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		pl_ack_i && pl_req_i |=> pl_ack_i) else $error("player ack fell before its req");

endmodule

bind mem_arbiter rhythm_assertions u_arb_checks (
	.clk_i(clk_i), .arst_n_i(arst_n_i),
	.ld_req_i(ld_req_i), .ld_cmd_i(ld_cmd_i), .ld_ack_i(ld_ack_o),
	.pl_req_i(pl_req_i), .pl_cmd_i(pl_cmd_i), .pl_ack_i(pl_ack_o)
);

`default_nettype wire

// File: verification/rhythm_tb.sv
/*
 * rhythm audio testbench
 * loads the pattern words over the four-phase port, decodes the I2S
 * stream and checks order, channels, underrun, completion and display
 */
`default_nettype none

module rhythm_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_WORDS      = 16;
	localparam int PREFILL        = 4;
	localparam int SCLK_HALF      = 4;
	localparam int SLOT_CLKS      = 32 * SCLK_HALF;	// clocks per sample slot
	localparam int UNDERRUN_PAUSE = 8 * SLOT_CLKS;	// starves the player
	// play time with headroom, plus load pauses and the starve gap
	localparam int WATCHDOG_NS = NUM_WORDS * 32 * 2 * SCLK_HALF * 10 * 4 +
		(2 * NUM_WORDS * 16 + UNDERRUN_PAUSE) * 10;

	logic                clk = 1'b0;
	logic                arst_n, load_req;
	rhythm_pkg::sample_t load_data;
	logic                load_ack, load_done, play_done, underrun;
	logic                i2s_sclk, i2s_lrclk, i2s_sd;
	rhythm_pkg::seg_t    hex0, hex1, hex2, hex3;

	logic [15:0] pat_mem [0:NUM_WORDS+3];	// words, then hex0..hex3 at the end
	logic [31:0] lfsr;
	int          sample_errs, seg_errs, flag_errs, other_errs;
	int          ack_rises = 0;
	int          stray_acks = 0;
	rhythm_pkg::sample_t dec_words [$];	// nonzero words seen on I2S
	logic                dec_chan [$];	// lrclk of each decoded word
	logic        prev_sclk, prev_lr;
	logic [15:0] dec_sh;

	rhythm_audio_top #(
		.NUM_WORDS(NUM_WORDS), .PREFILL(PREFILL), .SCLK_HALF(SCLK_HALF)
	) dut0 (
		.MAX10_CLK2_50(clk), .arst_n_i(arst_n),
		.load_req_i(load_req), .load_data_i(load_data),
		.load_ack_o(load_ack), .load_done_o(load_done),
		.i2s_sclk_o(i2s_sclk), .i2s_lrclk_o(i2s_lrclk), .i2s_sd_o(i2s_sd),
		.play_done_o(play_done), .underrun_o(underrun),
		.hex0_o(hex0), .hex1_o(hex1), .hex2_o(hex2), .hex3_o(hex3)
	);

	always #5 clk = ~clk;	// 100 MHz

	// ==================================================
	// I2S receiver and load ack monitor
	// ==================================================
	always @(negedge clk) begin
		if (!arst_n) begin
			prev_sclk = 1'b0;
			prev_lr   = 1'b0;
			dec_sh    = '0;
		end else begin
			if (i2s_sclk && !prev_sclk) begin	// receiver samples here
				// lrclk flipped, so this bit is the LSB of the word before
				if (i2s_lrclk != prev_lr && {dec_sh[14:0], i2s_sd} != 16'h0) begin
					dec_words.push_back({dec_sh[14:0], i2s_sd});
					dec_chan.push_back(prev_lr);
				end
				dec_sh  = {dec_sh[14:0], i2s_sd};
				prev_lr = i2s_lrclk;
			end
			prev_sclk = i2s_sclk;
		end
	end

	// counts each load ack rise and checks that req is already up
	always @(posedge load_ack) begin
		ack_rises++;
		if (!load_req) begin
			stray_acks++;
			$display("load_ack_o rose while load_req_i was low at %0t", $time);
		end
	end

	// ==================================================
	// compare tasks
	// ==================================================
	task automatic compare_sample(input string name, input rhythm_pkg::sample_t exp,
		input rhythm_pkg::sample_t act);
		if (exp !== act) begin
			sample_errs++;
			$display("** Error %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic compare_seg(input string name, input rhythm_pkg::seg_t exp,
		input rhythm_pkg::seg_t act);
		if (exp !== act) begin
			seg_errs++;
			$display("** Error %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic compare_flag(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			flag_errs++;
			$display("** Error %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	// ==================================================
	// stimulus
	// ==================================================
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);	// galois, right shift
	endfunction

	task automatic draw_pause(output int n);
		n = 0;
		repeat (2) begin	// one step per bit, 0..3 cycles
			lfsr = lfsr_step(lfsr);
			n    = (n << 1) | int'(lfsr[0]);
		end
	endtask

	task automatic apply_reset();
		@(negedge clk);
		arst_n   = 1'b0;
		load_req = 1'b0;
		repeat (5) @(negedge clk);
		arst_n = 1'b1;
	endtask

	task automatic send_word(input rhythm_pkg::sample_t w);
		@(negedge clk);
		load_data = w;	// held while req is high
		load_req  = 1'b1;
		while (!load_ack) @(negedge clk);
		load_req = 1'b0;
		while (load_ack) @(negedge clk);	// return to zero
	endtask

	task automatic load_words(input int first, input int last);
		int pause;
		for (int i = first; i <= last; i++) begin
			send_word(pat_mem[i]);
			draw_pause(pause);
			repeat (pause) @(negedge clk);
		end
	endtask

	task automatic check_i2s_low(input string run);
		compare_flag({run, " sclk"}, 1'b0, i2s_sclk);
		compare_flag({run, " lrclk"}, 1'b0, i2s_lrclk);
		compare_flag({run, " sd"}, 1'b0, i2s_sd);
	endtask

	task automatic finish_run(input string run, input logic exp_underrun, input int ack_base);
		while (!play_done) @(negedge clk);
		compare_flag({run, " load_done"}, 1'b1, load_done);
		compare_flag({run, " underrun"}, exp_underrun, underrun);
		check_i2s_low({run, " done"});
		compare_seg({run, " hex0"}, pat_mem[NUM_WORDS][6:0], hex0);
		compare_seg({run, " hex1"}, pat_mem[NUM_WORDS+1][6:0], hex1);
		compare_seg({run, " hex2"}, pat_mem[NUM_WORDS+2][6:0], hex2);
		compare_seg({run, " hex3"}, pat_mem[NUM_WORDS+3][6:0], hex3);
		if (ack_rises - ack_base != NUM_WORDS) begin
			other_errs++;
			$display("%s saw %0d load acks for %0d words", run, ack_rises - ack_base, NUM_WORDS);
		end
	endtask

	task automatic check_playback(input string run, input bit with_chan, input int base);
		int got;
		got = dec_words.size() - base;
		if (got != NUM_WORDS) begin
			other_errs++;
			$display("%s decoded %0d nonzero words instead of %0d", run, got, NUM_WORDS);
		end
		for (int i = 0; i < NUM_WORDS && i < got; i++) begin
			compare_sample($sformatf("%s word %0d", run, i), pat_mem[i], dec_words[base + i]);
			if (with_chan)	// even words left, odd right
				compare_flag($sformatf("%s lrclk %0d", run, i), i[0], dec_chan[base + i]);
		end
	endtask

	// ==================================================
	// test sequence
	// ==================================================
	initial begin
		int dec_base;
		int ack_base;
		arst_n      = 1'b0;
		load_req    = 1'b0;
		load_data   = '0;
		lfsr        = 32'hb558bca9;
		sample_errs = 0;
		seg_errs    = 0;
		flag_errs   = 0;
		other_errs  = 0;
		$readmemh("verification/audio_patterns.txt", pat_mem);

		// run 1, feed keeps ahead
		apply_reset();
		dec_base = dec_words.size();
		ack_base = ack_rises;
		@(negedge clk);
		compare_flag("reset load_ack", 1'b0, load_ack);
		compare_flag("reset load_done", 1'b0, load_done);
		compare_flag("reset play_done", 1'b0, play_done);
		compare_flag("reset underrun", 1'b0, underrun);
		check_i2s_low("reset");
		compare_seg("reset hex0", pat_mem[NUM_WORDS][6:0], hex0);	// digit 0
		load_words(0, NUM_WORDS - 1);
		compare_flag("run1 load_done after last", 1'b1, load_done);
		@(negedge clk);	// one more word, must be refused
		load_data = pat_mem[0];
		load_req  = 1'b1;
		repeat (20) @(negedge clk);
		compare_flag("run1 ack when full", 1'b0, load_ack);
		load_req = 1'b0;
		finish_run("run1", 1'b0, ack_base);
		check_playback("run1", 1'b1, dec_base);

		// run 2, player starves after five words
		apply_reset();
		dec_base = dec_words.size();
		ack_base = ack_rises;
		load_words(0, 4);
		repeat (UNDERRUN_PAUSE) @(negedge clk);
		load_words(5, NUM_WORDS - 1);
		finish_run("run2", 1'b1, ack_base);
		check_playback("run2", 1'b0, dec_base);

		$display("errors: %0d sample, %0d segment, %0d flag, %0d other",
			sample_errs, seg_errs, flag_errs, other_errs + stray_acks);
		if (sample_errs + seg_errs + flag_errs + other_errs + stray_acks == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

	// watchdog
	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired, playback not complete after %0d ns", WATCHDOG_NS);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire
